/* sim/issue_trace.txt */
# p inst0 pc0 id0 inst1 pc1 id1, all hex, slot 0 is the older instruction
# e lane id ref_id gap, all hex, gap is cycles after ref_id issued, ref_id 00 skips it
p 04221800 00000100 01 aca40000 00000104 02
e 0 01 00 0
e 1 02 01 0
p 8c260000 00000108 03 40470000 0000010c 04
e 1 03 00 0
e 0 04 03 0
p c0000040 00000110 05 18220000 00000114 06
e 0 05 00 0
e 0 06 05 1
p ac830000 00000118 07 84090020 0000011c 08
e 1 07 00 0
e 1 08 07 1
p 04224000 00000120 09 09034800 00000124 0a
e 0 09 00 0
e 1 0a 09 1
p 8c250000 00000128 0b 04a23000 0000012c 0c
e 1 0b 00 0
e 1 0c 0b 2
p 40410000 00000130 0d 20800000 00000134 0e
e 1 0d 00 0
e 0 0e 0d 0
p a4020010 00000138 0f 586a0000 0000013c 10
e 1 0f 00 0
e 0 10 0f 0

/* list.f */
hdl/dual_issue_pkg.sv
hdl/operand_decoder.sv
hdl/steering_unit.sv
hdl/hazard_detection_unit.sv
hdl/pair_buffer.sv
hdl/issue_register.sv
hdl/dual_issue_stage.sv
sim/tb_dual_issue_stage.sv

/* sim/tb_dual_issue_stage.sv */
`timescale 1ns/1ps

module tb_dual_issue_stage import dual_issue_pkg::*; ();

  typedef struct packed {
    logic [id_width-1:0] id;      // id expected next on the lane.
    logic [id_width-1:0] ref_id;  // earlier id for the timing check, 0 skips it.
    logic [7:0]          gap;     // cycles after ref_id issued.
  } expect_t;

  logic    clk;
  logic    rst_n;
  logic    fetch_req;
  pair_t   fetch_pair;
  logic    fetch_ack;
  lane_t   ex0;
  lane_t   ex1;

  pair_t   pair_q[$];             // pairs still to fetch.
  expect_t exp_q0[$];             // per lane issue order.
  expect_t exp_q1[$];
  slot_t   trace_slot [256];      // trace payload by id.
  int      issue_cycle [256];
  int      trace_lines  = 0;
  int      extra_issues = 0;
  int      cycle        = 0;
  integer  seed         = 32'hc956;
  logic    prev_req;
  logic    prev_ack;
  logic    prev_rst_n   = 1'b0;

  dual_issue_stage i_dual_issue_stage (
    .clk, .rst_n, .fetch_req, .fetch_pair, .fetch_ack, .ex0, .ex1
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;        // 40 ns period.
  end

  ////////////////////////////////////////////////////
  // failure reporting and checks
  ////////////////////////////////////////////////////

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected)
      stop_run($sformatf("mismatch %0t %s %0h %0h", $time, name, got, expected));
  endtask

  // one issued entry against trace payload and lane order.
  task automatic check_issue(input int lane, input slot_t s);
    expect_t e;
    check_value($sformatf("ex%0d instruction", lane), s.instruction,
                trace_slot[s.id].instruction);
    check_value($sformatf("ex%0d pc", lane), s.pc, trace_slot[s.id].pc);
    if ((lane == 0 && exp_q0.size() == 0) || (lane == 1 && exp_q1.size() == 0)) begin
      extra_issues++;                              // nothing left to match.
    end else begin
      if (lane == 0)
        e = exp_q0.pop_front();
      else
        e = exp_q1.pop_front();
      check_value($sformatf("ex%0d id", lane), s.id, e.id);
      if (e.ref_id != 0)
        check_value($sformatf("ex%0d issue gap", lane),
                    cycle - issue_cycle[e.ref_id], e.gap);
    end
  endtask

  ////////////////////////////////////////////////////
  // trace file
  ////////////////////////////////////////////////////

  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    logic [31:0] i0, p0, d0, i1, p1, d1;
    logic [31:0] lane, eid, rid, gap;
    fd = $fopen("sim/issue_trace.txt", "r");
    if (fd == 0)
      stop_run("cannot open trace file sim/issue_trace.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] == "p") begin
        n = $sscanf(line, "p %h %h %h %h %h %h", i0, p0, d0, i1, p1, d1);
        if (n != 6)
          stop_run("pair line in trace file does not hold six fields");
        pair_q.push_back('{slot0: '{i0, p0, d0[7:0]}, slot1: '{i1, p1, d1[7:0]}});
        trace_slot[d0[7:0]] = '{i0, p0, d0[7:0]};  // payload looked up by id.
        trace_slot[d1[7:0]] = '{i1, p1, d1[7:0]};
        trace_lines++;
      end else if (line.len() > 0 && line[0] == "e") begin
        n = $sscanf(line, "e %h %h %h %h", lane, eid, rid, gap);
        if (n != 4)
          stop_run("expect line in trace file does not hold four fields");
        if (lane == 0)
          exp_q0.push_back('{eid[7:0], rid[7:0], gap[7:0]});
        else
          exp_q1.push_back('{eid[7:0], rid[7:0], gap[7:0]});
        trace_lines++;
      end
    end
    $fclose(fd);
    if (trace_lines == 0)
      stop_run("trace file holds no pair or expect lines");
  endtask

  ////////////////////////////////////////////////////
  // fetch driver and end of run
  ////////////////////////////////////////////////////

  initial begin : fetch_driver
    pair_t p;
    int    idle;
    rst_n      = 1'b0;
    fetch_req  = 1'b0;
    fetch_pair = '0;
    for (int i = 0; i < 256; i++)
      issue_cycle[i] = -1000;                      // never issued.
    load_trace();
    repeat (10) @(posedge clk);                    // reset for 10 cycles.
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("fetch_ack", fetch_ack, 0);        // idle after reset.
    check_value("ex0.valid", ex0.valid, 0);
    check_value("ex1.valid", ex1.valid, 0);
    while (pair_q.size() != 0) begin
      p    = pair_q.pop_front();
      idle = {$random(seed)} % 4;                  // 0 to 3 idle cycles.
      repeat (idle) @(posedge clk);
      fetch_pair <= p;
      fetch_req  <= 1'b1;
      @(posedge clk);
      while (!fetch_ack) @(posedge clk);
      fetch_req <= 1'b0;                           // phase three.
      @(posedge clk);
      while (fetch_ack) @(posedge clk);
    end
    while (exp_q0.size() != 0 || exp_q1.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);                    // catch late extra entries.
    if (extra_issues != 0) begin
      stop_run($sformatf("%0d issued entries had no expect line", extra_issues));
    end else begin
      $display("sim passed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////
  // lane monitors and handshake check
  ////////////////////////////////////////////////////

  always @(posedge clk) begin : issue_monitor
    cycle = cycle + 1;
    if (rst_n) begin
      if (ex0.valid)
        issue_cycle[ex0.slot.id] = cycle;          // both lanes first, same-cycle refs.
      if (ex1.valid)
        issue_cycle[ex1.slot.id] = cycle;
      if (ex0.valid)
        check_issue(0, ex0.slot);
      if (ex1.valid)
        check_issue(1, ex1.slot);
      if (prev_rst_n && fetch_ack && !prev_ack)
        check_value("fetch_req at ack rise", prev_req, 1);
      if (prev_rst_n && !fetch_ack && prev_ack)
        check_value("fetch_req at ack fall", prev_req, 0);
    end
    prev_req   = fetch_req;
    prev_ack   = fetch_ack;
    prev_rst_n = rst_n;
  end

  initial begin : watchdog
    wait (rst_n === 1'b1);                         // trace is loaded by now.
    repeat (trace_lines * 20) @(posedge clk);      // 20 cycles per trace line.
    stop_run("watchdog expired, issue did not finish");
  end

endmodule

/* hdl/dual_issue_stage.sv */
`timescale 1ns/1ps

module dual_issue_stage import dual_issue_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  fetch_req,
  input  pair_t fetch_pair,
  output logic  fetch_ack,
  output lane_t ex0,
  output lane_t ex1
);

  pair_t               if_pair;
  decode_t             dec0;
  decode_t             dec1;
  slot_t               lane_slot0;
  slot_t               lane_slot1;
  decode_t             lane_dec0;
  decode_t             lane_dec1;
  logic                first;
  logic                steer_stall;
  pipe_mask_t          stall0;
  pipe_mask_t          stall1;
  pipe_mask_t          flush0;
  pipe_mask_t          flush1;
  logic [1:0]          slot_stall;
  logic [1:0]          slot_clear;
  logic                pc_stall;
  logic [reg_log2-1:0] load_rt;
  mem_op_t             mem_op;

  assign pc_stall = stall0.pc | stall1.pc;            // either lane blocks fetch.

  //////////////////////////////////////////////////
  // if/id and decode
  //////////////////////////////////////////////////

  pair_buffer i_pair_buffer (
    .clk, .rst_n, .fetch_req, .fetch_pair, .fetch_ack,
    .slot_stall, .slot_clear, .pc_stall, .if_pair
  );

  operand_decoder i_decoder0 (.instruction(if_pair.slot0.instruction), .dec(dec0));
  operand_decoder i_decoder1 (.instruction(if_pair.slot1.instruction), .dec(dec1));

  //////////////////////////////////////////////////
  // steering, hazards and id/ex
  //////////////////////////////////////////////////

  steering_unit i_steering_unit (
    .pair(if_pair), .dec0, .dec1, .stall0, .stall1, .flush0, .flush1,
    .lane_slot0, .lane_slot1, .lane_dec0, .lane_dec1,
    .first, .steer_stall, .slot_stall, .slot_clear
  );

  hazard_detection_unit i_hazard_detection_unit (
    .dec0(lane_dec0), .dec1(lane_dec1), .first, .steer_stall,
    .load_rt, .mem_op, .stall0, .stall1, .flush0, .flush1
  );

  issue_register i_issue_register (
    .clk, .rst_n, .lane_slot0, .lane_slot1, .flush0, .flush1,
    .lane_dec1, .ex0, .ex1, .load_rt, .mem_op
  );

endmodule

/* hdl/issue_register.sv */
`timescale 1ns/1ps

module issue_register import dual_issue_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  slot_t               lane_slot0,
  input  slot_t               lane_slot1,
  input  pipe_mask_t          flush0,
  input  pipe_mask_t          flush1,
  input  decode_t             lane_dec1,
  output lane_t               ex0,
  output lane_t               ex1,
  output logic [reg_log2-1:0] load_rt,
  output mem_op_t             mem_op
);

  logic issue0;
  logic issue1;

  // bubble on id_ex flush or nop slot.
  assign issue0 = !flush0.id_ex && (lane_slot0.instruction != nop_instruction);
  assign issue1 = !flush1.id_ex && (lane_slot1.instruction != nop_instruction);

  always_ff @(posedge clk) begin
    ex0.slot <= lane_slot0;                          // payload follows every cycle.
    ex1.slot <= lane_slot1;
    load_rt  <= lane_dec1.rt;                        // load target for hazard check.
    if (!rst_n) begin
      ex0.valid <= 1'b0;
      ex1.valid <= 1'b0;
      mem_op    <= mem_none;
    end else begin
      ex0.valid <= issue0;
      ex1.valid <= issue1;
      mem_op    <= issue1 ? lane_dec1.mem_op : mem_none;  // bubble is no access.
    end
  end

endmodule

/* hdl/pair_buffer.sv */
`timescale 1ns/1ps

module pair_buffer import dual_issue_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_req,
  input  pair_t      fetch_pair,
  output logic       fetch_ack,
  input  logic [1:0] slot_stall,
  input  logic [1:0] slot_clear,
  input  logic       pc_stall,
  output pair_t      if_pair
);

  pair_t      pair_q;      // if/id payload.
  logic [1:0] valid_q;     // per slot occupancy.
  logic [1:0] drain;       // slot leaves this cycle.
  logic       room;
  logic       accept;

  //////////////////////////////////////////////////
  // four-phase accept
  //////////////////////////////////////////////////

  assign drain  = slot_clear & ~slot_stall;          // held slots never drain.
  assign room   = &(~valid_q | drain);               // both slots free next edge.
  assign accept = fetch_req && !fetch_ack && !pc_stall && room;

  always_ff @(posedge clk) begin
    if (accept)
      pair_q <= fetch_pair;                          // capture on accept only.
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q   <= 2'b00;                            // empty after reset.
      fetch_ack <= 1'b0;
    end else begin
      if (accept)
        valid_q <= 2'b11;
      else
        valid_q <= valid_q & ~drain;                 // issued slots become nops.
      if (accept)
        fetch_ack <= 1'b1;                           // ack one cycle after capture.
      else if (!fetch_req)
        fetch_ack <= 1'b0;                           // drop once req is gone.
    end
  end

  //////////////////////////////////////////////////
  // empty slots read as nop
  //////////////////////////////////////////////////

  always_comb begin
    if_pair = pair_q;
    if (!valid_q[0])
      if_pair.slot0 = nop_slot;
    if (!valid_q[1])
      if_pair.slot1 = nop_slot;
  end

endmodule

/* hdl/hazard_detection_unit.sv */
`timescale 1ns/1ps

module hazard_detection_unit import dual_issue_pkg::*; (
  input  decode_t             dec0,
  input  decode_t             dec1,
  input  logic                first,
  input  logic                steer_stall,
  input  logic [reg_log2-1:0] load_rt,
  input  mem_op_t             mem_op,
  output pipe_mask_t          stall0,
  output pipe_mask_t          stall1,
  output pipe_mask_t          flush0,
  output pipe_mask_t          flush1
);

  decode_t             older;
  decode_t             younger;
  logic [reg_log2-1:0] older_wr;      // register the older lane writes.
  logic                load_stall;
  logic                split_stall;

  // true when d actually reads register r.
  function automatic logic reads_reg(input decode_t d, input logic [reg_log2-1:0] r);
    return (d.src.rs && d.rs == r) || (d.src.rt && d.rt == r);
  endfunction

  //////////////////////////////////////////////////
  // hazard checks
  //////////////////////////////////////////////////

  assign older    = first ? dec1 : dec0;           // lane 1 older when first.
  assign younger  = first ? dec0 : dec1;
  assign older_wr = older.dst.rd ? older.rd : older.rt;

  // load in id/ex lane 1 against both lanes.
  assign load_stall = (mem_op == mem_read) &&
                      (reads_reg(dec0, load_rt) || reads_reg(dec1, load_rt));

  // raw inside one pair.
  assign split_stall = (older.dst != reg_none) && reads_reg(younger, older_wr);

  //////////////////////////////////////////////////
  // mask generation
  //////////////////////////////////////////////////

  always_comb begin
    stall0 = '0;                                   // no stall, both issue.
    stall1 = '0;
    flush0 = '0;
    flush1 = '0;
    if (load_stall) begin
      stall0 = mask_hold;                          // hold pair, bubble both.
      flush0 = mask_flush_ex;
      stall1 = mask_hold;
      flush1 = mask_flush_ex;
    end else if (split_stall || steer_stall) begin
      if (first) begin
        stall1 = mask_pc;                          // older lane 1 issues.
        flush1 = mask_flush_if;
        stall0 = mask_hold;                        // younger waits.
        flush0 = mask_flush_ex;
      end else begin
        stall0 = mask_pc;                          // older lane 0 issues.
        flush0 = mask_flush_if;
        stall1 = mask_hold;
        flush1 = mask_flush_ex;
      end
    end
  end

endmodule

/* hdl/steering_unit.sv */
`timescale 1ns/1ps

module steering_unit import dual_issue_pkg::*; (
  input  pair_t      pair,
  input  decode_t    dec0,
  input  decode_t    dec1,
  input  pipe_mask_t stall0,
  input  pipe_mask_t stall1,
  input  pipe_mask_t flush0,
  input  pipe_mask_t flush1,
  output slot_t      lane_slot0,
  output slot_t      lane_slot1,
  output decode_t    lane_dec0,
  output decode_t    lane_dec1,
  output logic       first,
  output logic       steer_stall,
  output logic [1:0] slot_stall,
  output logic [1:0] slot_clear
);

  logic [1:0] lane_hold;   // per lane, if_id stalled.
  logic [1:0] lane_drop;   // per lane, slot leaves if_id.

  //////////////////////////////////////////////////
  // lane order, lane 0 branch/alu and lane 1 memory
  //////////////////////////////////////////////////

  always_comb begin
    lane_slot0  = pair.slot0;                        // straight order.
    lane_slot1  = pair.slot1;
    lane_dec0   = dec0;
    lane_dec1   = dec1;
    first       = 1'b0;
    steer_stall = 1'b0;
    case ({dec0.pipe, dec1.pipe})
      {pipe_branch, pipe_branch}: begin
        lane_slot1  = nop_slot;                      // slot 1 waits a cycle.
        lane_dec1   = '0;
        steer_stall = 1'b1;
      end
      {pipe_memory, pipe_memory}: begin
        lane_slot0  = nop_slot;                      // only one memory port.
        lane_dec0   = '0;
        lane_slot1  = pair.slot0;
        lane_dec1   = dec0;
        first       = 1'b1;
        steer_stall = 1'b1;
      end
      {pipe_memory, pipe_branch},
      {pipe_memory, pipe_dont_care},
      {pipe_dont_care, pipe_branch}: begin
        lane_slot0  = pair.slot1;                    // swap lanes.
        lane_slot1  = pair.slot0;
        lane_dec0   = dec1;
        lane_dec1   = dec0;
        first       = 1'b1;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // lane masks back onto raw slots
  //////////////////////////////////////////////////

  assign lane_hold = {stall1.if_id, stall0.if_id};
  assign lane_drop = {flush1.if_id | ~stall1.if_id, flush0.if_id | ~stall0.if_id};

  always_comb begin
    if (first) begin
      slot_stall = {lane_hold[0], lane_hold[1]};     // slot 0 rides lane 1.
      slot_clear = {lane_drop[0], lane_drop[1]};
    end else begin
      slot_stall = lane_hold;
      slot_clear = lane_drop;
    end
  end

endmodule

/* hdl/operand_decoder.sv */
`timescale 1ns/1ps

module operand_decoder import dual_issue_pkg::*; (
  input  logic [inst_width-1:0] instruction,
  output decode_t               dec
);

  logic [5:0] opcode;

  assign opcode = instruction[opcode_msb:opcode_lsb];

  always_comb begin
    dec        = '0;                                 // nop by default.
    dec.rs     = instruction[rs_msb:rs_lsb];
    dec.rt     = instruction[rt_msb:rt_lsb];
    dec.rd     = instruction[rd_msb:rd_lsb];
    casez (opcode)
      op_nop: begin
        dec.src = reg_none;                          // no fields at all.
        dec.dst = reg_none;
      end
      op_jr: begin
        dec.src  = reg_rs;                           // jump target in rs.
        dec.pipe = pipe_branch;                      // a jump, so branch pipe.
      end
      6'b00????: begin
        dec.src = reg_rs_rt;                         // add, sub and friends.
        dec.dst = reg_rd;
        if (opcode == op_cmp || opcode == op_test)
          dec.pipe = pipe_branch;                    // flags go to branch pipe.
      end
      6'b01????: begin
        dec.src = reg_rs;                            // immediate forms.
        dec.dst = reg_rt;
        if (opcode == op_cmpi || opcode == op_testi)
          dec.pipe = pipe_branch;
      end
      6'b10????: begin
        dec.pipe = pipe_memory;                      // whole group is memory.
        if (opcode == op_lw) begin
          dec.src    = reg_rs;                       // base in rs.
          dec.dst    = reg_rt;
          dec.mem_op = mem_read;
        end else if (opcode == op_sw) begin
          dec.src    = reg_rs_rt;                    // base and store data.
          dec.mem_op = mem_write;
        end else if (opcode == op_la) begin
          dec.dst    = reg_rt;                       // absolute load.
        end else if (opcode == op_sa) begin
          dec.src    = reg_rt;                       // absolute store.
        end
      end
      default: begin
        dec.pipe = pipe_branch;                      // jmp, je, jo ...
      end
    endcase
  end

endmodule

/* hdl/dual_issue_pkg.sv */
package dual_issue_pkg;

  //////////////////////////////////////////////////
  // widths and field positions
  //////////////////////////////////////////////////

  localparam int inst_width = 32;  // one instruction word.
  localparam int addr_width = 32;  // pc width.
  localparam int id_width   = 8;   // instruction id from fetch.
  localparam int reg_log2   = 5;   // 32 architectural registers.

  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;

  //////////////////////////////////////////////////
  // opcodes, class set by the top two bits
  //////////////////////////////////////////////////

  localparam logic [5:0] op_nop   = 6'b000000;
  localparam logic [5:0] op_cmp   = 6'b000110;  // reg-reg compare, feeds branch pipe.
  localparam logic [5:0] op_test  = 6'b000111;
  localparam logic [5:0] op_jr    = 6'b001000;  // sits in the 00 group.
  localparam logic [5:0] op_cmpi  = 6'b010110;  // immediate compare.
  localparam logic [5:0] op_testi = 6'b010111;
  localparam logic [5:0] op_la    = 6'b100001;
  localparam logic [5:0] op_lw    = 6'b100011;
  localparam logic [5:0] op_sa    = 6'b101001;
  localparam logic [5:0] op_sw    = 6'b101011;

  localparam logic [inst_width-1:0] nop_instruction = '0;

  //////////////////////////////////////////////////
  // masks and enums
  //////////////////////////////////////////////////

  typedef struct packed {
    logic rd;
    logic rt;
    logic rs;
  } reg_mask_t;

  typedef struct packed {
    logic id_ex;
    logic if_id;
    logic pc;
  } pipe_mask_t;

  localparam reg_mask_t reg_none  = '0;
  localparam reg_mask_t reg_rs    = '{rs: 1'b1, default: 1'b0};
  localparam reg_mask_t reg_rt    = '{rt: 1'b1, default: 1'b0};
  localparam reg_mask_t reg_rd    = '{rd: 1'b1, default: 1'b0};
  localparam reg_mask_t reg_rs_rt = '{rs: 1'b1, rt: 1'b1, default: 1'b0};

  localparam pipe_mask_t mask_pc       = '{pc: 1'b1, default: 1'b0};
  localparam pipe_mask_t mask_hold     = '{pc: 1'b1, if_id: 1'b1, default: 1'b0};
  localparam pipe_mask_t mask_flush_if = '{if_id: 1'b1, default: 1'b0};
  localparam pipe_mask_t mask_flush_ex = '{id_ex: 1'b1, default: 1'b0};

  typedef enum logic [1:0] {pipe_dont_care, pipe_branch, pipe_memory} pipe_class_t;
  typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_op_t;

  //////////////////////////////////////////////////
  // payload structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [inst_width-1:0] instruction;
    logic [addr_width-1:0] pc;
    logic [id_width-1:0]   id;
  } slot_t;

  typedef struct packed {
    slot_t slot0;  // older instruction.
    slot_t slot1;
  } pair_t;

  typedef struct packed {
    reg_mask_t           src;
    reg_mask_t           dst;
    logic [reg_log2-1:0] rs;
    logic [reg_log2-1:0] rt;
    logic [reg_log2-1:0] rd;
    pipe_class_t         pipe;
    mem_op_t             mem_op;
  } decode_t;

  typedef struct packed {
    logic  valid;
    slot_t slot;
  } lane_t;

  localparam slot_t nop_slot = '{instruction: nop_instruction, pc: '0, id: '0};

endpackage
